// ==== Makefile ====
# Verilator build and run of the memory stage testbench.

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
BUILD_DIR ?= obj_dir
FILE_LIST ?= tb.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
HEADERS := $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf $(BUILD_DIR)

// ==== include/mem_vectors.svh ====
/* stimulus table for the memory stage testbench: one access per entry,
   with store data or a random-data flag, the expected fault and idle cycles after it. */

`ifndef MEM_VECTORS_SVH
`define MEM_VECTORS_SVH

typedef struct packed {
    mem_pkg::funct3_t  funct3;
    logic              is_store;
    mem_pkg::reg_idx_t rd;
    mem_pkg::word_t    base;
    logic [11:0]       imm;
    mem_pkg::word_t    store_data;
    logic              use_random; // take data from the LCG instead.
    logic              exp_fault;
    logic [1:0]        gap;        // idle cycles after this entry.
} mem_vec_t;

localparam int NUM_VECTORS = 40;

// funct3: 0 byte, 1 half, 2 word, 4 byte unsigned, 5 half unsigned.
localparam mem_vec_t VECTORS [NUM_VECTORS] = '{
    '{3'h2, 1'b1, 5'd0,  32'h0000_0100, 12'h000, 32'hdead_beef, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd1,  32'h0000_0100, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd1},
    '{3'h2, 1'b1, 5'd0,  32'h0000_0120, 12'hffc, 32'h0000_0000, 1'b1, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd2,  32'h0000_0118, 12'h004, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b1, 5'd0,  32'h0000_0140, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h0, 1'b1, 5'd0,  32'h0000_0140, 12'h000, 32'h1234_56c3, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd22, 32'h0000_0140, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h0, 1'b1, 5'd0,  32'h0000_0141, 12'h000, 32'h0000_0071, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd23, 32'h0000_0140, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h0, 1'b1, 5'd0,  32'h0000_0142, 12'h000, 32'hffff_ff80, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd24, 32'h0000_0140, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h0, 1'b1, 5'd0,  32'h0000_0150, 12'hff3, 32'h0000_005a, 1'b0, 1'b0, 2'd1},
    '{3'h0, 1'b0, 5'd3,  32'h0000_0140, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h4, 1'b0, 5'd4,  32'h0000_0140, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h0, 1'b0, 5'd5,  32'h0000_0142, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h4, 1'b0, 5'd6,  32'h0000_0143, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd7,  32'h0000_0140, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd1},
    '{3'h2, 1'b1, 5'd0,  32'h0000_0160, 12'h000, 32'h1122_3344, 1'b0, 1'b0, 2'd0},
    '{3'h1, 1'b1, 5'd0,  32'h0000_0160, 12'h000, 32'habcd_8001, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd25, 32'h0000_0160, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h1, 1'b1, 5'd0,  32'h0000_0170, 12'hff2, 32'h0000_7ffe, 1'b0, 1'b0, 2'd0},
    '{3'h1, 1'b0, 5'd8,  32'h0000_0160, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h5, 1'b0, 5'd9,  32'h0000_0160, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h1, 1'b0, 5'd10, 32'h0000_0162, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h5, 1'b0, 5'd11, 32'h0000_0162, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd1},
    '{3'h1, 1'b0, 5'd12, 32'h0000_0101, 12'h000, 32'h0000_0000, 1'b0, 1'b1, 2'd0},
    '{3'h2, 1'b0, 5'd13, 32'h0000_0102, 12'h000, 32'h0000_0000, 1'b0, 1'b1, 2'd0},
    '{3'h1, 1'b1, 5'd0,  32'h0000_0163, 12'h000, 32'hffff_ffff, 1'b0, 1'b1, 2'd0},
    '{3'h2, 1'b1, 5'd0,  32'h0000_0161, 12'h000, 32'hffff_ffff, 1'b0, 1'b1, 2'd0},
    '{3'h3, 1'b0, 5'd14, 32'h0000_0100, 12'h000, 32'h0000_0000, 1'b0, 1'b1, 2'd0},
    '{3'h4, 1'b1, 5'd0,  32'h0000_0100, 12'h000, 32'h0000_0000, 1'b0, 1'b1, 2'd0},
    '{3'h6, 1'b0, 5'd15, 32'h0000_0100, 12'h000, 32'h0000_0000, 1'b0, 1'b1, 2'd1},
    '{3'h2, 1'b0, 5'd16, 32'h0000_0100, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd17, 32'h0000_0160, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd2},
    '{3'h2, 1'b1, 5'd0,  32'h0000_0180, 12'h000, 32'h0000_0000, 1'b1, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd18, 32'h0000_0180, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h0, 1'b1, 5'd0,  32'h0000_0183, 12'h000, 32'h0000_00a5, 1'b0, 1'b0, 2'd0},
    '{3'h0, 1'b0, 5'd19, 32'h0000_0183, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h2, 1'b0, 5'd20, 32'h0000_0180, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0},
    '{3'h5, 1'b0, 5'd21, 32'h0000_0182, 12'h000, 32'h0000_0000, 1'b0, 1'b0, 2'd0}
};

`endif

// ==== dv/tb_mem_stage.sv ====
/* testbench for the memory stage: clock and reset, table-driven requests,
   byte-array reference memory, response queue checks and a cycle timeout. */

`default_nettype none

module tb_mem_stage;

    timeunit 1ns;
    timeprecision 1ps;

    `include "mem_vectors.svh"

    localparam int RESET_CYCLES = 5;
    localparam int LATENCY      = 2; // negedge drive to negedge sample of the response.

    typedef struct packed {
        mem_pkg::mem_rsp_t rsp;
        int                due_cycle;
    } expect_t;

    bit                clk;
    bit                rst_n;
    bit                req_valid;
    mem_pkg::mem_req_t req;
    bit                rsp_valid;
    mem_pkg::mem_rsp_t rsp;

    logic [7:0]     ref_mem [mem_pkg::MEM_WORDS*4]; // byte image of the RAM.
    expect_t        pending [$];
    mem_pkg::word_t lcg_state = 32'd19442;
    int             cycle_count = 0;
    int             cycle_limit;
    int             value_errors = 0;
    int             protocol_errors = 0;

    always #50 clk = ~clk;

    mem_stage_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    function automatic mem_pkg::word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // only the bytes covered by the access size change.
    task automatic update_model(mem_pkg::funct3_t funct3, mem_pkg::word_t addr,
                                mem_pkg::word_t data);
        logic [9:0] a;
        a = addr[9:0];
        ref_mem[a] = data[7:0];
        if (funct3 != mem_pkg::FUNCT3_LB_SB) begin
            ref_mem[a + 10'd1] = data[15:8];
        end
        if (funct3 == mem_pkg::FUNCT3_LW_SW) begin
            ref_mem[a + 10'd2] = data[23:16];
            ref_mem[a + 10'd3] = data[31:24];
        end
    endtask

    function automatic mem_pkg::word_t predict_load(mem_pkg::funct3_t funct3,
                                                    mem_pkg::word_t addr);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[9:0];
        b = ref_mem[a];
        h = {ref_mem[a + 10'd1], ref_mem[a]};
        case (funct3)
            mem_pkg::FUNCT3_LB_SB : return {{24{b[7]}}, b};
            mem_pkg::FUNCT3_LBU   : return {24'h0, b};
            mem_pkg::FUNCT3_LH_SH : return {{16{h[15]}}, h};
            mem_pkg::FUNCT3_LHU   : return {16'h0, h};
            mem_pkg::FUNCT3_LW_SW : return {ref_mem[a + 10'd3], ref_mem[a + 10'd2], h};
            default               : return '0;
        endcase
    endfunction

    task automatic check_response(expect_t exp);
        assert (exp.due_cycle == cycle_count) else begin
            $display("response for rd %0d came at cycle %0d, expected at cycle %0d",
                     exp.rsp.rd, cycle_count, exp.due_cycle);
            protocol_errors++;
        end
        assert (rsp.rd == exp.rsp.rd) else begin
            $display("CHECK FAILED rsp.rd expected 0x%h got 0x%h", exp.rsp.rd, rsp.rd);
            value_errors++;
        end
        assert (rsp.load_data == exp.rsp.load_data) else begin
            $display("CHECK FAILED rsp.load_data expected 0x%h got 0x%h",
                     exp.rsp.load_data, rsp.load_data);
            value_errors++;
        end
        assert (rsp.fault == exp.rsp.fault) else begin
            $display("CHECK FAILED rsp.fault expected 0x%h got 0x%h", exp.rsp.fault, rsp.fault);
            value_errors++;
        end
        assert (rsp.was_store == exp.rsp.was_store) else begin
            $display("CHECK FAILED rsp.was_store expected 0x%h got 0x%h",
                     exp.rsp.was_store, rsp.was_store);
            value_errors++;
        end
    endtask

    // responses are sampled on the falling edge, away from the DUT's clock edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (rsp_valid) begin
                assert (pending.size() != 0) else begin
                    $display("extra response at cycle %0d with no request outstanding",
                             cycle_count);
                    protocol_errors++;
                end
                if (pending.size() != 0) begin
                    check_response(pending.pop_front());
                end
            end else if (pending.size() != 0) begin
                assert (pending[0].due_cycle > cycle_count) else begin
                    $display("missing response for rd %0d, due at cycle %0d",
                             pending[0].rsp.rd, pending[0].due_cycle);
                    protocol_errors++;
                    void'(pending.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, responses still outstanding", cycle_limit);
            $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        mem_pkg::mem_req_t next_req;
        expect_t           exp;
        mem_pkg::word_t    addr;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        cycle_limit = RESET_CYCLES + 20;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            cycle_limit += 1 + int'(VECTORS[i].gap);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_VECTORS; i++) begin
            addr = VECTORS[i].base + {{20{VECTORS[i].imm[11]}}, VECTORS[i].imm};
            next_req.funct3     = VECTORS[i].funct3;
            next_req.is_store   = VECTORS[i].is_store;
            next_req.rd         = VECTORS[i].rd;
            next_req.base       = VECTORS[i].base;
            next_req.imm        = VECTORS[i].imm;
            next_req.store_data = VECTORS[i].use_random ? next_random()
                                                        : VECTORS[i].store_data;

            exp.rsp.rd        = VECTORS[i].rd;
            exp.rsp.fault     = VECTORS[i].exp_fault;
            exp.rsp.was_store = VECTORS[i].is_store;
            exp.rsp.load_data = '0; // stores and faults return zero.
            if (!VECTORS[i].exp_fault) begin
                if (VECTORS[i].is_store) begin
                    update_model(VECTORS[i].funct3, addr, next_req.store_data);
                end else begin
                    exp.rsp.load_data = predict_load(VECTORS[i].funct3, addr);
                end
            end
            exp.due_cycle = cycle_count + LATENCY;
            pending.push_back(exp);

            req       = next_req;
            req_valid = 1'b1;
            @(negedge clk);
            req_valid = 1'b0;
            repeat (VECTORS[i].gap) @(negedge clk);
        end

        while (pending.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk); // room for a stray response.

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/data_ram.sv ====
/* data memory: MEM_WORDS words, byte lane write enables,
   write on the clock edge and combinational read. */

`default_nettype none

module data_ram (
    input  bit                                  clk,
    input  logic [mem_pkg::MEM_ADDR_BITS-1:0]   word_addr,
    input  mem_pkg::wstrobe_t                   wstrobe,
    input  mem_pkg::word_t                      wdata,
    output mem_pkg::word_t                      rdata
);

    mem_pkg::word_t mem [mem_pkg::MEM_WORDS]; // contents survive reset.

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (wstrobe[lane]) begin
                mem[word_addr][lane*8 +: 8] <= wdata[lane*8 +: 8];
            end
        end
    end

    // a store at this edge is visible to the access in the next cycle.
    assign rdata = mem[word_addr];

endmodule

`default_nettype wire

// ==== source/load_writeback.sv ====
/* response register toward the register file: destination, load result,
   fault and store flags, one strobe per access. */

`default_nettype none

module load_writeback (
    input  bit                clk,
    input  bit                rst_n,
    input  bit                acc_valid,
    input  mem_pkg::mem_acc_t acc,
    input  mem_pkg::word_t    load_data,
    output bit                rsp_valid,
    output mem_pkg::mem_rsp_t rsp
);

    logic load_ok; // a load that passed the checks.

    assign load_ok = acc.is_load & ~acc.fault;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_valid) begin
            rsp.rd        <= acc.rd;
            rsp.load_data <= load_ok ? load_data : '0;
            rsp.fault     <= acc.fault;
            rsp.was_store <= ~acc.is_load; // also set for a store that faulted.
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_agu.sv ====
/* address generation: base plus sign-extended immediate, funct3 and
   alignment checks, and the registered access handed to the rest of the stage. */

`default_nettype none

module mem_agu (
    input  bit                clk,
    input  bit                rst_n,
    input  bit                req_valid,
    input  mem_pkg::mem_req_t req,
    output bit                acc_valid,
    output mem_pkg::mem_acc_t acc
);

    mem_pkg::word_t address;    // effective byte address.
    logic           bad_code;   // funct3 not legal for this direction.
    logic           misaligned;
    logic           fault;

    assign address = req.base + {{20{req.imm[11]}}, req.imm};

    always_comb begin
        bad_code   = 1'b0;
        misaligned = 1'b0;
        case (req.funct3)
            mem_pkg::FUNCT3_LB_SB : misaligned = 1'b0; // bytes are always aligned.
            mem_pkg::FUNCT3_LBU   : bad_code   = req.is_store;
            mem_pkg::FUNCT3_LH_SH : misaligned = address[0];
            mem_pkg::FUNCT3_LHU   : begin
                bad_code   = req.is_store; // there is no unsigned store.
                misaligned = address[0];
            end
            mem_pkg::FUNCT3_LW_SW : misaligned = |address[1:0];
            default               : bad_code   = 1'b1;
        endcase
    end

    assign fault = bad_code | misaligned;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= req_valid;
        end
    end

    // payload only moves with a request.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            acc.funct3     <= req.funct3;
            acc.is_store   <= req.is_store & ~fault; // keeps memory untouched on a fault.
            acc.is_load    <= ~req.is_store;
            acc.rd         <= req.rd;
            acc.address    <= address;
            acc.store_data <= req.store_data;
            acc.fault      <= fault;
        end
    end

endmodule

`default_nettype wire

// ==== source/mem_align.sv ====
/* byte lane steering: store data replication with write strobes,
   and load lane selection with sign or zero extension. */

`default_nettype none

module mem_align (
    input  bit                acc_valid,
    input  mem_pkg::mem_acc_t acc,
    input  mem_pkg::word_t    rdata,
    output mem_pkg::wstrobe_t wstrobe,
    output mem_pkg::word_t    wdata,
    output mem_pkg::word_t    load_data
);

    logic       store_enable;
    logic [1:0] align_byte;  // byte offset in the word.
    logic       align_half;  // upper or lower half-word.
    logic [7:0]  rdata_byte;
    logic [15:0] rdata_half;

    assign store_enable = acc_valid & acc.is_store;
    assign align_byte   = acc.address[1:0];
    assign align_half   = acc.address[1];

    always_comb begin
        wstrobe = '0;
        case (acc.funct3)
            mem_pkg::FUNCT3_LB_SB : begin
                wdata   = {4{acc.store_data[7:0]}};
                wstrobe = mem_pkg::wstrobe_t'(store_enable) << align_byte;
            end
            mem_pkg::FUNCT3_LH_SH : begin
                wdata   = {2{acc.store_data[15:0]}};
                wstrobe = align_half ? {{2{store_enable}}, 2'b00}
                                     : {2'b00, {2{store_enable}}};
            end
            mem_pkg::FUNCT3_LW_SW : begin
                wdata   = acc.store_data;
                wstrobe = {4{store_enable}};
            end
            default : begin
                wdata   = acc.store_data; // faults land here, strobe stays zero.
            end
        endcase
    end

    assign rdata_byte = rdata[{align_byte, 3'b000} +: 8];
    assign rdata_half = rdata[{align_half, 4'b0000} +: 16];

    always_comb begin
        case (acc.funct3)
            mem_pkg::FUNCT3_LB_SB : load_data = {{24{rdata_byte[7]}}, rdata_byte};
            mem_pkg::FUNCT3_LBU   : load_data = {24'h0, rdata_byte};
            mem_pkg::FUNCT3_LH_SH : load_data = {{16{rdata_half[15]}}, rdata_half};
            mem_pkg::FUNCT3_LHU   : load_data = {16'h0, rdata_half};
            default               : load_data = rdata; // whole word.
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
/* shared types of the memory stage: word, strobe, funct3 and register index,
   the RV32I load/store codes, RAM depth, and the request, access and response structs. */

`default_nettype none

package mem_pkg;

    typedef logic [31:0] word_t;    // data or address word.
    typedef logic [3:0]  wstrobe_t; // one enable per byte lane.
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  reg_idx_t;

    // access size and signedness, as in the RV32I encoding.
    localparam funct3_t FUNCT3_LB_SB = 3'd0;
    localparam funct3_t FUNCT3_LH_SH = 3'd1;
    localparam funct3_t FUNCT3_LW_SW = 3'd2;
    localparam funct3_t FUNCT3_LBU   = 3'd4;
    localparam funct3_t FUNCT3_LHU   = 3'd5;

    localparam int MEM_WORDS     = 256; // 1 KiB of data memory.
    localparam int MEM_ADDR_BITS = 8;   // word index, taken from address bits 9:2.

    typedef struct packed {
        funct3_t     funct3;
        logic        is_store;
        reg_idx_t    rd;
        word_t       base;
        logic [11:0] imm;        // I or S immediate, already assembled.
        word_t       store_data;
    } mem_req_t;

    typedef struct packed {
        funct3_t  funct3;
        logic     is_store;   // low for a faulting store.
        logic     is_load;
        reg_idx_t rd;
        word_t    address;
        word_t    store_data;
        logic     fault;
    } mem_acc_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    load_data;  // zero unless a load succeeded.
        logic     fault;
        logic     was_store;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== source/mem_stage_top.sv ====
/* memory access stage: address unit, lane alignment, data RAM and
   response register. */

`default_nettype none

module mem_stage_top (
    input  bit                clk,
    input  bit                rst_n,
    input  bit                req_valid,
    input  mem_pkg::mem_req_t req,
    output bit                rsp_valid,
    output mem_pkg::mem_rsp_t rsp
);

    bit                                acc_valid;
    mem_pkg::mem_acc_t                 acc;
    mem_pkg::wstrobe_t                 wstrobe;
    mem_pkg::word_t                    wdata;
    mem_pkg::word_t                    rdata;
    mem_pkg::word_t                    load_data;
    logic [mem_pkg::MEM_ADDR_BITS-1:0] word_addr;

    assign word_addr = acc.address[mem_pkg::MEM_ADDR_BITS+1:2]; // drop the byte offset.

    mem_agu u_agu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .acc_valid (acc_valid),
        .acc       (acc)
    );

    mem_align u_align (
        .acc_valid (acc_valid),
        .acc       (acc),
        .rdata     (rdata),
        .wstrobe   (wstrobe),
        .wdata     (wdata),
        .load_data (load_data)
    );

    data_ram u_ram (
        .clk       (clk),
        .word_addr (word_addr),
        .wstrobe   (wstrobe),
        .wdata     (wdata),
        .rdata     (rdata)
    );

    load_writeback u_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_valid (acc_valid),
        .acc       (acc),
        .load_data (load_data),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/mem_pkg.sv
source/mem_agu.sv
source/mem_align.sv
source/data_ram.sv
source/load_writeback.sv
source/mem_stage_top.sv
dv/tb_mem_stage.sv
